// File: all.f
design/sb_mixer_pkg.sv
design/sb_io_decode.sv
design/sb_mixer_regs.sv
design/sb_sample_mix.sv
design/sb_mixer_top.sv
bench/sb_mixer_sva.sv
bench/sb_mixer_tb.sv

// File: bench/sb_mixer_sva.sv
// host handshake and sample pipeline assertions, bound into the decoder and the mixer
`timescale 1ns/1ps

module sb_mixer_sva (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic ack,
	input logic reg_wr,
	input logic in_valid,
	input logic out_valid
);

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
		else $error("ack rose without req");

	// ack only drops once the host lets go of req
	a_ack_held: assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
		else $error("ack fell while req was still high");

	// one write strobe, inside a live request
	a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n) reg_wr |-> req ##1 !reg_wr)
		else $error("reg_wr outside a request or longer than one cycle");

	a_valid_out: assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after in_valid");

	a_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, 2))
		else $error("out_valid without in_valid two cycles before");

endmodule

bind sb_io_decode sb_mixer_sva u_io_sva (.clk(clk), .rst_n(rst_n), .req(req), .ack(ack),
	.reg_wr(reg_wr), .in_valid(1'b0), .out_valid(1'b0));

bind sb_sample_mix sb_mixer_sva u_mix_sva (.clk(clk), .rst_n(rst_n), .req(1'b0), .ack(1'b0),
	.reg_wr(1'b0), .in_valid(in_valid), .out_valid(out_valid));

// File: bench/sb_mixer_tb.sv
// mixer testbench with host handshake tasks, reference models, directed tests and timeout
`timescale 1ns/1ps

module sb_mixer_tb;
	import sb_mixer_pkg::*;

	localparam int MAX_CYCLES = 4000;  // about 150 handshakes plus the sample bursts

	logic       clk, rst_n, req, we, ack, irq8, irq16, in_valid, out_valid;
	logic       dma16_en, stereo, irq_5, irq_7, irq_10;
	logic [1:0] vol_spk;
	io_addr_t   addr;
	io_data_t   wdata, rdata;
	sample_t    dsp_l, dsp_r, fm_l, fm_r, sample_l, sample_r;
	vol_t       vol_cd_l, vol_cd_r, vol_line_l, vol_line_r;
	int         errors;
	int         cycles = 0;

	sb_mixer_top u_sb_mixer_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("the run timed out after %0d cycles with tests still running", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check(input string what, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// sampled away from the rising edge
	task automatic wait_ack(input logic level);
		@(negedge clk);
		while (ack !== level)
			@(negedge clk);
	endtask

	task automatic host_write(input io_addr_t a, input io_data_t d);
		@(posedge clk);
		req   <= 1'b1;
		we    <= 1'b1;
		addr  <= a;
		wdata <= d;
		wait_ack(1'b1);
		@(posedge clk);
		req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic host_read(input io_addr_t a, output io_data_t d);
		@(posedge clk);
		req  <= 1'b1;
		we   <= 1'b0;
		addr <= a;
		wait_ack(1'b1);
		d = rdata;  // valid while ack is high
		@(posedge clk);
		req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic write_reg(input mix_index_t i, input io_data_t d);
		host_write(ADDR_INDEX, i);
		host_write(ADDR_DATA, d);
	endtask

	task automatic read_reg(input mix_index_t i, input io_data_t exp);
		io_data_t got;
		host_write(ADDR_INDEX, i);
		host_read(ADDR_DATA, got);
		check($sformatf("reg %02h", i), int'(got), int'(exp));
	endtask

	// nibble repeated by its top bit, sbpro keeps only three bits
	function automatic vol_t expanded_level(input logic [3:0] nib, input logic pro);
		return pro ? {nib[3:1], nib[3:2]} : {nib, nib[3]};
	endfunction

	function automatic int scaled_sample(input int s, input vol_t v);
		if (v == 5'd0)
			return 0;
		return s >>> (15 - int'(v[4:1]));
	endfunction

	function automatic int mixed(input sample_t d, input sample_t f,
			input vol_t vm, input vol_t vv, input vol_t vf);
		int sum;
		sum = (scaled_sample(int'(d), vv) >>> 1) + (scaled_sample(int'(f), vf) >>> 1);
		return scaled_sample(sum, vm);
	endfunction

	task automatic reset_defaults();
		io_data_t got;
		read_reg(IDX_MASTER, 8'hff);
		read_reg(IDX_CD, 8'hff);
		read_reg(IDX_SPK, 8'hc0);  // speaker level 3 in the top bits
		read_reg(IDX_IRQ, 8'h02);
		read_reg(IDX_DMA, 8'h22);
		check("stereo", int'(stereo), 0);
		host_read(ADDR_INDEX, got);
		check("index readback", int'(got), int'(IDX_DMA));
		host_read(4'd0, got);
		check("offset 0", int'(got), 255);
		host_read(4'd9, got);
		check("offset 9", int'(got), 255);
	endtask

	task automatic sb16_volumes();
		write_reg(IDX_CD, 8'ha5);
		check("vol_cd_l", int'(vol_cd_l), int'(expanded_level(4'ha, 1'b0)));
		check("vol_cd_r", int'(vol_cd_r), int'(expanded_level(4'h5, 1'b0)));
		read_reg(IDX_CD, 8'ha5);
		read_reg(IDX_CD_L, {expanded_level(4'ha, 1'b0), 3'd0});
		write_reg(IDX_LINE_L, 8'h5b);
		check("vol_line_l", int'(vol_line_l), 11);
		read_reg(IDX_LINE, 8'h5f);  // right channel still full scale
		read_reg(IDX_LINE_L, 8'h58);
	endtask

	task automatic sbpro_mode();
		write_reg(IDX_STEREO, 8'h02);
		check("stereo in sb16", int'(stereo), 0);
		write_reg(IDX_IRQ, SBP_ON);
		read_reg(IDX_MASTER, MASK_SBP);  // all ones under the sbpro mask
		read_reg(IDX_MASTER_L, 8'h00);
		write_reg(IDX_MASTER_L, 8'h00);
		write_reg(IDX_LINE, 8'h97);
		check("vol_line_l", int'(vol_line_l), int'(expanded_level(4'h9, 1'b1)));
		check("vol_line_r", int'(vol_line_r), int'(expanded_level(4'h7, 1'b1)));
		read_reg(IDX_LINE, 8'h86);
		write_reg(IDX_STEREO, 8'h02);
		check("stereo in sbpro", int'(stereo), 1);
		read_reg(IDX_STEREO, 8'h02);
		write_reg(IDX_IRQ, SBP_OFF);
		read_reg(IDX_MASTER_L, 8'hf8);
		read_reg(IDX_MASTER, 8'hff);
	endtask

	task automatic drive_irq(input logic i8, input logic i16, input logic [1:0] sel);
		@(posedge clk);
		irq8  <= i8;
		irq16 <= i16;
		@(negedge clk);
		check("irq_5", int'(irq_5), int'((i8 | i16) & (sel == 2'b00)));
		check("irq_7", int'(irq_7), int'((i8 | i16) & (sel == 2'b01)));
		check("irq_10", int'(irq_10), int'((i8 | i16) & (sel == 2'b10)));
		read_reg(IDX_STATUS, {6'd0, i16, i8});
	endtask

	task automatic irq_dma_routing();
		logic [1:0] sel;
		sel = 2'b00;
		repeat (3) begin  // irq 5, 7 and 10
			write_reg(IDX_IRQ, {4'h0, sel, 2'b00});
			read_reg(IDX_IRQ, {4'h0, sel == 2'b10, sel == 2'b01, sel == 2'b00, 1'b0});
			drive_irq(1'b1, 1'b0, sel);
			drive_irq(1'b0, 1'b1, sel);
			drive_irq(1'b0, 1'b0, sel);
			sel = sel + 2'b01;
		end
		write_reg(IDX_DMA, 8'h00);
		check("dma16_en", int'(dma16_en), 0);
		read_reg(IDX_DMA, 8'h02);
		write_reg(IDX_DMA, 8'h20);
		check("dma16_en", int'(dma16_en), 1);
		write_reg(IDX_IRQ, 8'h08);
		write_reg(IDX_DMA, 8'h00);
		write_reg(IDX_SPK, 8'h40);
		check("vol_spk", int'(vol_spk), 1);
		write_reg(IDX_RESET, 8'h00);
		read_reg(IDX_IRQ, 8'h02);
		read_reg(IDX_DMA, 8'h22);
		read_reg(IDX_SPK, 8'hc0);
		read_reg(IDX_LINE, 8'hff);
		check("vol_cd_l", int'(vol_cd_l), 31);
		check("vol_spk", int'(vol_spk), 3);
		check("stereo", int'(stereo), 0);
	endtask

	task automatic sample_mixing(input vol_t vm, input vol_t vv, input vol_t vf, input int n);
		int          exp_l[$];
		int          exp_r[$];
		logic [31:0] ra;
		logic [31:0] rb;
		write_reg(IDX_MASTER_L, {vm, 3'd0});
		write_reg(IDX_MASTER_R, {vm, 3'd0});
		write_reg(IDX_VOICE_L, {vv, 3'd0});
		write_reg(IDX_VOICE_R, {vv, 3'd0});
		write_reg(IDX_FM_L, {vf, 3'd0});
		write_reg(IDX_FM_R, {vf, 3'd0});
		for (int i = 0; i < n + 2; i++) begin
			@(posedge clk);
			in_valid <= (i < n);
			if (i < n) begin
				ra = $urandom;
				rb = $urandom;
				dsp_l <= ra[15:0];
				dsp_r <= ra[31:16];
				fm_l  <= rb[15:0];
				fm_r  <= rb[31:16];
				exp_l.push_back(mixed(ra[15:0], rb[15:0], vm, vv, vf));
				exp_r.push_back(mixed(ra[31:16], rb[31:16], vm, vv, vf));
			end
			@(negedge clk);
			check("out_valid", int'(out_valid), int'(i >= 2));  // two cycles behind
			if (i >= 2) begin
				check("sample_l", int'(sample_l), exp_l.pop_front());
				check("sample_r", int'(sample_r), exp_r.pop_front());
			end
		end
	endtask

	initial begin
		void'($urandom(32'h2da1));
		errors = 0;
		clk    = 1'b0;
		rst_n    <= 1'b0;
		req      <= 1'b0;
		we       <= 1'b0;
		addr     <= '0;
		wdata    <= '0;
		irq8     <= 1'b0;
		irq16    <= 1'b0;
		in_valid <= 1'b0;
		dsp_l    <= '0;
		dsp_r    <= '0;
		fm_l     <= '0;
		fm_r     <= '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		reset_defaults();
		sb16_volumes();
		sbpro_mode();
		irq_dma_routing();
		sample_mixing(5'd31, 5'd31, 5'd31, 16);
		sample_mixing(5'd24, 5'd0, 5'd20, 16);   // voice muted
		sample_mixing(5'd0, 5'd31, 5'd31, 16);   // master muted
		sample_mixing(5'd17, 5'd1, 5'd28, 16);
		$display("%0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: design/sb_io_decode.sv
// host req/ack FSM, mixer index register, register write strobe and read data capture
`timescale 1ns/1ps

module sb_io_decode
	import sb_mixer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       req,
	input  logic       we,
	input  io_addr_t   addr,
	input  io_data_t   wdata,
	input  io_data_t   reg_rdata,
	output logic       ack,
	output io_data_t   rdata,
	output mix_index_t index,
	output logic       reg_wr
);

	io_state_t state;
	io_data_t  rd_value;

	// data writes land in the register file during exec
	assign reg_wr = (state == IO_EXEC) && we && (addr == ADDR_DATA);

	always_comb begin
		case (addr)
			ADDR_INDEX: rd_value = index;
			ADDR_DATA:  rd_value = reg_rdata;
			default:    rd_value = 8'hff;  // nothing else lives in the window
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IO_IDLE;
			ack   <= 1'b0;
			index <= '0;
		end else begin
			case (state)
				IO_IDLE: begin
					if (req)
						state <= IO_EXEC;
				end
				IO_EXEC: begin
					if (we && addr == ADDR_INDEX)
						index <= wdata;
					state <= IO_HOLD;
				end
				IO_HOLD: begin
					// ack rises one cycle into hold, drops once req is released
					if (ack && !req) begin
						ack   <= 1'b0;
						state <= IO_IDLE;
					end else begin
						ack <= 1'b1;
					end
				end
				default: state <= IO_IDLE;
			endcase
		end
	end

	// read value frozen for the whole ack phase
	always_ff @(posedge clk) begin
		if (state == IO_EXEC && !we)
			rdata <= rd_value;
	end

endmodule

// File: design/sb_mixer_pkg.sv
// mixer types, register index constants, reset defaults and decoder state enum
package sb_mixer_pkg;

	typedef logic [3:0]         io_addr_t;   // offset inside the host window
	typedef logic [7:0]         io_data_t;
	typedef logic [7:0]         mix_index_t;
	typedef logic [4:0]         vol_t;       // 0 mute, 31 full scale
	typedef logic signed [15:0] sample_t;

	typedef enum logic [1:0] {
		IO_IDLE,
		IO_EXEC,
		IO_HOLD
	} io_state_t;

	// host window offsets
	localparam io_addr_t ADDR_INDEX = 4'd4;
	localparam io_addr_t ADDR_DATA  = 4'd5;

	// packed sbpro style registers
	localparam mix_index_t IDX_RESET    = 8'h00;
	localparam mix_index_t IDX_VOICE    = 8'h04;
	localparam mix_index_t IDX_STEREO   = 8'h0e;
	localparam mix_index_t IDX_MASTER   = 8'h22;
	localparam mix_index_t IDX_FM       = 8'h26;
	localparam mix_index_t IDX_CD       = 8'h28;
	localparam mix_index_t IDX_LINE     = 8'h2e;

	// sb16 per channel registers
	localparam mix_index_t IDX_MASTER_L = 8'h30;
	localparam mix_index_t IDX_MASTER_R = 8'h31;
	localparam mix_index_t IDX_VOICE_L  = 8'h32;
	localparam mix_index_t IDX_VOICE_R  = 8'h33;
	localparam mix_index_t IDX_FM_L     = 8'h34;
	localparam mix_index_t IDX_FM_R     = 8'h35;
	localparam mix_index_t IDX_CD_L     = 8'h36;
	localparam mix_index_t IDX_CD_R     = 8'h37;
	localparam mix_index_t IDX_LINE_L   = 8'h38;
	localparam mix_index_t IDX_LINE_R   = 8'h39;
	localparam mix_index_t IDX_SPK      = 8'h3b;
	localparam mix_index_t IDX_IRQ      = 8'h80;
	localparam mix_index_t IDX_DMA      = 8'h81;
	localparam mix_index_t IDX_STATUS   = 8'h82;

	localparam vol_t       VOL_DEFAULT   = 5'h1f;
	localparam logic [1:0] SPK_DEFAULT   = 2'd3;
	localparam logic       DMA16_DEFAULT = 1'b1;

	// bytes written to 80h that switch the sbpro mode
	localparam io_data_t SBP_ON  = 8'had;
	localparam io_data_t SBP_OFF = 8'hae;

	localparam io_data_t MASK_SBP  = 8'hee;  // sbpro keeps 3 bits per channel
	localparam io_data_t MASK_SB16 = 8'hff;

endpackage

// File: design/sb_mixer_regs.sv
// mixer register file with volume expansion, mode bits, irq routing and readback mux
`timescale 1ns/1ps

module sb_mixer_regs
	import sb_mixer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mix_index_t index,
	input  logic       reg_wr,
	input  io_data_t   wdata,
	input  logic       irq8,
	input  logic       irq16,
	output io_data_t   reg_rdata,
	output vol_t       vol_master_l,
	output vol_t       vol_master_r,
	output vol_t       vol_voice_l,
	output vol_t       vol_voice_r,
	output vol_t       vol_fm_l,
	output vol_t       vol_fm_r,
	output vol_t       vol_cd_l,
	output vol_t       vol_cd_r,
	output vol_t       vol_line_l,
	output vol_t       vol_line_r,
	output logic [1:0] vol_spk,
	output logic       dma16_en,
	output logic       stereo,
	output logic       irq_5,
	output logic       irq_7,
	output logic       irq_10
);

	logic     sbp;
	logic     irq7_sel;
	logic     irq10_sel;
	logic     irq5_sel;
	logic     defaults;
	vol_t     pk_l;
	vol_t     pk_r;
	io_data_t vol_mask;
	io_data_t sb16_rdata;

	// nibble to 5 bit level, sbpro only carries three bits of it
	function automatic vol_t expand(input logic [3:0] nib, input logic pro);
		if (pro)
			expand = {nib[3:1], nib[3:2]};
		else
			expand = {nib, nib[3]};
	endfunction

	assign pk_l     = expand(wdata[7:4], sbp);
	assign pk_r     = expand(wdata[3:0], sbp);
	assign defaults = !rst_n || (reg_wr && index == IDX_RESET);

	always_ff @(posedge clk) begin
		if (defaults) begin
			vol_master_l <= VOL_DEFAULT;
			vol_master_r <= VOL_DEFAULT;
			vol_voice_l  <= VOL_DEFAULT;
			vol_voice_r  <= VOL_DEFAULT;
			vol_fm_l     <= VOL_DEFAULT;
			vol_fm_r     <= VOL_DEFAULT;
			vol_cd_l     <= VOL_DEFAULT;
			vol_cd_r     <= VOL_DEFAULT;
			vol_line_l   <= VOL_DEFAULT;
			vol_line_r   <= VOL_DEFAULT;
			vol_spk      <= SPK_DEFAULT;
			dma16_en     <= DMA16_DEFAULT;
			stereo       <= 1'b0;
			sbp          <= 1'b0;
			irq7_sel     <= 1'b0;
			irq10_sel    <= 1'b0;
		end else if (reg_wr) begin
			case (index)
				IDX_VOICE:  {vol_voice_l, vol_voice_r}   <= {pk_l, pk_r};
				IDX_MASTER: {vol_master_l, vol_master_r} <= {pk_l, pk_r};
				IDX_FM:     {vol_fm_l, vol_fm_r}         <= {pk_l, pk_r};
				IDX_CD:     {vol_cd_l, vol_cd_r}         <= {pk_l, pk_r};
				IDX_LINE:   {vol_line_l, vol_line_r}     <= {pk_l, pk_r};
				IDX_STEREO: begin
					if (sbp)
						stereo <= wdata[1];
				end
				IDX_IRQ: begin
					if (wdata == SBP_ON)
						sbp <= 1'b1;
					else if (wdata == SBP_OFF)
						sbp <= 1'b0;
					else begin
						irq7_sel  <= (wdata[3:2] == 2'b01);
						irq10_sel <= (wdata[3:2] == 2'b10);
					end
				end
				IDX_DMA: dma16_en <= wdata[5];
				default: begin
					if (!sbp) begin  // per channel levels are sb16 only
						case (index)
							IDX_MASTER_L: vol_master_l <= wdata[7:3];
							IDX_MASTER_R: vol_master_r <= wdata[7:3];
							IDX_VOICE_L:  vol_voice_l  <= wdata[7:3];
							IDX_VOICE_R:  vol_voice_r  <= wdata[7:3];
							IDX_FM_L:     vol_fm_l     <= wdata[7:3];
							IDX_FM_R:     vol_fm_r     <= wdata[7:3];
							IDX_CD_L:     vol_cd_l     <= wdata[7:3];
							IDX_CD_R:     vol_cd_r     <= wdata[7:3];
							IDX_LINE_L:   vol_line_l   <= wdata[7:3];
							IDX_LINE_R:   vol_line_r   <= wdata[7:3];
							IDX_SPK:      vol_spk      <= wdata[7:6];
							default:      ;
						endcase
					end
				end
			endcase
		end
	end

	assign irq5_sel = !irq7_sel && !irq10_sel;  // irq 5 when nothing else chosen
	assign irq_5    = (irq8 || irq16) && irq5_sel;
	assign irq_7    = (irq8 || irq16) && irq7_sel;
	assign irq_10   = (irq8 || irq16) && irq10_sel;

	assign vol_mask = sbp ? MASK_SBP : MASK_SB16;

	always_comb begin
		case (index)
			IDX_MASTER_L: sb16_rdata = {vol_master_l, 3'd0};
			IDX_MASTER_R: sb16_rdata = {vol_master_r, 3'd0};
			IDX_VOICE_L:  sb16_rdata = {vol_voice_l, 3'd0};
			IDX_VOICE_R:  sb16_rdata = {vol_voice_r, 3'd0};
			IDX_FM_L:     sb16_rdata = {vol_fm_l, 3'd0};
			IDX_FM_R:     sb16_rdata = {vol_fm_r, 3'd0};
			IDX_CD_L:     sb16_rdata = {vol_cd_l, 3'd0};
			IDX_CD_R:     sb16_rdata = {vol_cd_r, 3'd0};
			IDX_LINE_L:   sb16_rdata = {vol_line_l, 3'd0};
			IDX_LINE_R:   sb16_rdata = {vol_line_r, 3'd0};
			IDX_SPK:      sb16_rdata = {vol_spk, 6'd0};
			IDX_IRQ:      sb16_rdata = {4'h0, irq10_sel, irq7_sel, irq5_sel, 1'b0};
			IDX_DMA:      sb16_rdata = {2'b00, dma16_en, 1'b0, 4'h2};  // dma 5 and 1
			IDX_STATUS:   sb16_rdata = {6'd0, irq16, irq8};
			default:      sb16_rdata = 8'h00;
		endcase
	end

	always_comb begin
		case (index)
			IDX_VOICE:  reg_rdata = {vol_voice_l[4:1], vol_voice_r[4:1]} & vol_mask;
			IDX_MASTER: reg_rdata = {vol_master_l[4:1], vol_master_r[4:1]} & vol_mask;
			IDX_FM:     reg_rdata = {vol_fm_l[4:1], vol_fm_r[4:1]} & vol_mask;
			IDX_CD:     reg_rdata = {vol_cd_l[4:1], vol_cd_r[4:1]} & vol_mask;
			IDX_LINE:   reg_rdata = {vol_line_l[4:1], vol_line_r[4:1]} & vol_mask;
			IDX_STEREO: reg_rdata = {6'd0, stereo, 1'b0};
			default:    reg_rdata = sbp ? 8'h00 : sb16_rdata;
		endcase
	end

endmodule

// File: design/sb_mixer_top.sv
// mixer top level connecting host decoder, register file and sample mixer
`timescale 1ns/1ps

module sb_mixer_top
	import sb_mixer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// host port
	input  logic       req,
	input  logic       we,
	input  io_addr_t   addr,
	input  io_data_t   wdata,
	output logic       ack,
	output io_data_t   rdata,
	// dsp interrupt lines
	input  logic       irq8,
	input  logic       irq16,
	// sample stream
	input  logic       in_valid,
	input  sample_t    dsp_l,
	input  sample_t    dsp_r,
	input  sample_t    fm_l,
	input  sample_t    fm_r,
	output logic       out_valid,
	output sample_t    sample_l,
	output sample_t    sample_r,
	// levels for the analog sources outside
	output vol_t       vol_cd_l,
	output vol_t       vol_cd_r,
	output vol_t       vol_line_l,
	output vol_t       vol_line_r,
	output logic [1:0] vol_spk,
	output logic       dma16_en,
	output logic       stereo,
	output logic       irq_5,
	output logic       irq_7,
	output logic       irq_10
);

	mix_index_t index;
	logic       reg_wr;
	io_data_t   reg_rdata;
	vol_t       vol_master_l;
	vol_t       vol_master_r;
	vol_t       vol_voice_l;
	vol_t       vol_voice_r;
	vol_t       vol_fm_l;
	vol_t       vol_fm_r;

	sb_io_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.we        (we),
		.addr      (addr),
		.wdata     (wdata),
		.reg_rdata (reg_rdata),
		.ack       (ack),
		.rdata     (rdata),
		.index     (index),
		.reg_wr    (reg_wr)
	);

	sb_mixer_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.index        (index),
		.reg_wr       (reg_wr),
		.wdata        (wdata),  // host holds it stable while req is up
		.irq8         (irq8),
		.irq16        (irq16),
		.reg_rdata    (reg_rdata),
		.vol_master_l (vol_master_l),
		.vol_master_r (vol_master_r),
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_fm_l     (vol_fm_l),
		.vol_fm_r     (vol_fm_r),
		.vol_cd_l     (vol_cd_l),
		.vol_cd_r     (vol_cd_r),
		.vol_line_l   (vol_line_l),
		.vol_line_r   (vol_line_r),
		.vol_spk      (vol_spk),
		.dma16_en     (dma16_en),
		.stereo       (stereo),
		.irq_5        (irq_5),
		.irq_7        (irq_7),
		.irq_10       (irq_10)
	);

	sb_sample_mix u_mix (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.dsp_l        (dsp_l),
		.dsp_r        (dsp_r),
		.fm_l         (fm_l),
		.fm_r         (fm_r),
		.vol_master_l (vol_master_l),
		.vol_master_r (vol_master_r),
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_fm_l     (vol_fm_l),
		.vol_fm_r     (vol_fm_r),
		.out_valid    (out_valid),
		.sample_l     (sample_l),
		.sample_r     (sample_r)
	);

endmodule

// File: design/sb_sample_mix.sv
// two stage sample pipeline with channel volume, dsp plus fm sum and master volume
`timescale 1ns/1ps

module sb_sample_mix
	import sb_mixer_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_valid,
	input  sample_t dsp_l,
	input  sample_t dsp_r,
	input  sample_t fm_l,
	input  sample_t fm_r,
	input  vol_t    vol_master_l,
	input  vol_t    vol_master_r,
	input  vol_t    vol_voice_l,
	input  vol_t    vol_voice_r,
	input  vol_t    vol_fm_l,
	input  vol_t    vol_fm_r,
	output logic    out_valid,
	output sample_t sample_l,
	output sample_t sample_r
);

	logic    s1_valid;
	sample_t s1_dsp_l;
	sample_t s1_dsp_r;
	sample_t s1_fm_l;
	sample_t s1_fm_r;
	vol_t    s1_vm_l;
	vol_t    s1_vm_r;
	sample_t sum_l;
	sample_t sum_r;

	// each step of the level's top nibble is 6 dB
	function automatic sample_t scale(input sample_t s, input vol_t v);
		logic [3:0] sh;
		sh = 4'd15 - v[4:1];
		if (v == '0)
			scale = '0;
		else
			scale = s >>> sh;
	endfunction

	// halves keep the sum inside 16 bits
	assign sum_l = (s1_dsp_l >>> 1) + (s1_fm_l >>> 1);
	assign sum_r = (s1_dsp_r >>> 1) + (s1_fm_r >>> 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_dsp_l <= scale(dsp_l, vol_voice_l);
			s1_dsp_r <= scale(dsp_r, vol_voice_r);
			s1_fm_l  <= scale(fm_l, vol_fm_l);
			s1_fm_r  <= scale(fm_r, vol_fm_r);
			s1_vm_l  <= vol_master_l;  // master level travels with its sample
			s1_vm_r  <= vol_master_r;
		end
		if (s1_valid) begin
			sample_l <= scale(sum_l, s1_vm_l);
			sample_r <= scale(sum_r, s1_vm_r);
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module sb_mixer_tb -f all.f -o sb_mixer_sim
./obj_dir/sb_mixer_sim | tee sim.log
grep -q "^Simulation PASSED$" sim.log
